// ==== qdr_pkg.sv ====
`default_nettype none

package qdr_pkg;

  // one beat on the data bus is four 9-bit lanes.
  localparam int QDR_LANE_W = 9;
  localparam int QDR_LANES  = 4;
  localparam int QDR_WORD_W = QDR_LANE_W * QDR_LANES;

  typedef logic [QDR_WORD_W-1:0] qdr_word_t;

  // what a bank does in the current cycle.
  // a burst is two beats, the second addresses the upper four lanes.
  typedef enum logic [2:0] {
    QDR_OP_IDLE = 3'd0,
    QDR_OP_RD0  = 3'd1, // read lanes 0 to 3.
    QDR_OP_RD1  = 3'd2, // read lanes 4 to 7.
    QDR_OP_WR0  = 3'd3, // write lanes 0 to 3.
    QDR_OP_WR1  = 3'd4  // write lanes 4 to 7.
  } qdr_op_e;

endpackage

`default_nettype wire

// ==== qdr_bank_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface qdr_bank_if #(
  parameter int BANK_DEPTH = 1024
);
  import qdr_pkg::*;

  // read and write sides run on separate ports, as on a real QDR part.
  qdr_op_e                         rd_op;
  logic [$clog2(BANK_DEPTH)-1:0]   rd_row;
  qdr_op_e                         wr_op;
  logic [$clog2(BANK_DEPTH)-1:0]   wr_row;
  logic [QDR_LANES-1:0]            be;
  qdr_word_t                       wr_data;
  qdr_word_t                       rd_data; // registered beat from the bank.

  modport decode (
    output rd_op, rd_row, wr_op, wr_row, be, wr_data
  );

  modport bank (
    input  rd_op, rd_row, wr_op, wr_row, be, wr_data,
    output rd_data
  );

  modport ret (
    input  rd_data
  );

endinterface

`default_nettype wire

// ==== qdr_req_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module qdr_req_decode #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 1024,
  parameter int ADDR_W     = 32
) (
  input  logic                           qdr_clk,
  input  logic                           sys_rst,
  input  logic [ADDR_W-1:0]              addr,
  input  logic                           rd_en,
  input  logic                           wr_en,
  input  logic [qdr_pkg::QDR_LANES-1:0]  be,
  input  qdr_pkg::qdr_word_t             wr_data,
  qdr_bank_if.decode                     bank_if [NUM_BANKS],
  output logic                           rd_tag_valid,
  output logic [$clog2(NUM_BANKS)-1:0]   rd_tag_bank
);
  import qdr_pkg::*;

  localparam int ROW_W  = $clog2(BANK_DEPTH);
  localparam int BANK_W = $clog2(NUM_BANKS);

  logic              second_read;
  logic              second_write;
  logic              first_read;
  logic              first_write;
  logic [ROW_W-1:0]  addr_row;
  logic [BANK_W-1:0] addr_bank;
  logic [ROW_W-1:0]  row_z;
  logic [BANK_W-1:0] bank_z;
  logic [ROW_W-1:0]  rd_row;
  logic [BANK_W-1:0] rd_bank;
  logic [ROW_W-1:0]  wr_row;
  logic [BANK_W-1:0] wr_bank;
  qdr_op_e           rd_op;
  qdr_op_e           wr_op;

  assign addr_row  = addr[ROW_W-1:0];
  assign addr_bank = addr[ROW_W +: BANK_W]; // higher address bits alias.

  // a read wins over a write that starts in the same cycle.
  assign first_read  = rd_en && !second_read;
  assign first_write = !first_read && wr_en && !second_write;

  always_ff @(posedge qdr_clk) begin
    if (sys_rst) begin
      second_read  <= 1'b0;
      second_write <= 1'b0;
    end else begin
      second_read  <= first_read;
      second_write <= first_write;
    end
  end

  // the previous cycle's address is the one a second beat needs.
  always_ff @(posedge qdr_clk) begin
    row_z  <= addr_row;
    bank_z <= addr_bank;
  end

  assign rd_row  = second_read  ? row_z  : addr_row;
  assign rd_bank = second_read  ? bank_z : addr_bank;
  assign wr_row  = second_write ? row_z  : addr_row;
  assign wr_bank = second_write ? bank_z : addr_bank;

  always_comb begin
    rd_op = QDR_OP_IDLE;
    wr_op = QDR_OP_IDLE;
    if (first_read) begin
      rd_op = QDR_OP_RD0;
    end else if (second_read) begin
      rd_op = QDR_OP_RD1;
    end
    if (first_write) begin
      wr_op = QDR_OP_WR0;
    end else if (second_write) begin
      wr_op = QDR_OP_WR1;
    end
  end

  assign rd_tag_valid = (rd_op != QDR_OP_IDLE);
  assign rd_tag_bank  = rd_bank;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    assign bank_if[i].rd_op   = (rd_bank == BANK_W'(i)) ? rd_op : QDR_OP_IDLE;
    assign bank_if[i].wr_op   = (wr_bank == BANK_W'(i)) ? wr_op : QDR_OP_IDLE;
    assign bank_if[i].rd_row  = rd_row;
    assign bank_if[i].wr_row  = wr_row;
    assign bank_if[i].be      = be;
    assign bank_if[i].wr_data = wr_data;
  end

endmodule

`default_nettype wire

// ==== qdr_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module qdr_bank #(
  parameter int BANK_DEPTH = 1024
) (
  input  logic    qdr_clk,
  qdr_bank_if.bank bus
);
  import qdr_pkg::*;

  // lanes 0 to 3 hold the first beat, lanes 4 to 7 the second.
  logic [QDR_LANE_W-1:0] lane_mem [2*QDR_LANES][BANK_DEPTH];
  qdr_word_t             rd_q;

  always_ff @(posedge qdr_clk) begin
    for (int l = 0; l < QDR_LANES; l++) begin
      if (bus.be[l]) begin
        case (bus.wr_op)
          QDR_OP_WR0: begin
            lane_mem[l][bus.wr_row] <= bus.wr_data[l*QDR_LANE_W +: QDR_LANE_W];
          end
          QDR_OP_WR1: begin
            lane_mem[l+QDR_LANES][bus.wr_row] <= bus.wr_data[l*QDR_LANE_W +: QDR_LANE_W];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // a read in the same cycle as a write to its row returns the old lanes.
  always_ff @(posedge qdr_clk) begin
    for (int l = 0; l < QDR_LANES; l++) begin
      case (bus.rd_op)
        QDR_OP_RD0: begin
          rd_q[l*QDR_LANE_W +: QDR_LANE_W] <= lane_mem[l][bus.rd_row];
        end
        QDR_OP_RD1: begin
          rd_q[l*QDR_LANE_W +: QDR_LANE_W] <= lane_mem[l+QDR_LANES][bus.rd_row];
        end
        default: begin
        end
      endcase
    end
  end

  assign bus.rd_data = rd_q; // holds the last beat when idle.

endmodule

`default_nettype wire

// ==== qdr_read_return.sv ====
`timescale 1ns/1ns
`default_nettype none

module qdr_read_return #(
  parameter int NUM_BANKS   = 4,
  parameter int QDR_LATENCY = 10
) (
  input  logic                          qdr_clk,
  input  logic                          sys_rst,
  qdr_bank_if.ret                       bank_if [NUM_BANKS],
  input  logic                          rd_tag_valid,
  input  logic [$clog2(NUM_BANKS)-1:0]  rd_tag_bank,
  output qdr_pkg::qdr_word_t            rd_data
);
  import qdr_pkg::*;

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int STAGES = QDR_LATENCY - 1; // the bank register makes up the rest.

  qdr_word_t         bank_word [NUM_BANKS];
  logic              tag_valid_q;
  logic [BANK_W-1:0] tag_bank_q;
  qdr_word_t         sel_word;
  qdr_word_t         pipe_data [STAGES];
  logic [STAGES-1:0] pipe_valid;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_word
    assign bank_word[i] = bank_if[i].rd_data;
  end

  // the tag lines up with the beat the bank registered on the same edge.
  assign sel_word = tag_valid_q ? bank_word[tag_bank_q] : '0;

  always_ff @(posedge qdr_clk) begin
    if (sys_rst) begin
      tag_valid_q <= 1'b0;
      pipe_valid  <= '0;
    end else begin
      tag_valid_q   <= rd_tag_valid;
      pipe_valid[0] <= tag_valid_q;
      for (int s = 1; s < STAGES; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  always_ff @(posedge qdr_clk) begin
    tag_bank_q   <= rd_tag_bank;
    pipe_data[0] <= sel_word;
    for (int s = 1; s < STAGES; s++) begin
      pipe_data[s] <= pipe_data[s-1];
    end
  end

  assign rd_data = pipe_valid[STAGES-1] ? pipe_data[STAGES-1] : '0;

endmodule

`default_nettype wire

// ==== qdr_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module qdr_subsystem #(
  parameter int NUM_BANKS   = 4,
  parameter int BANK_DEPTH  = 1024,
  parameter int QDR_LATENCY = 10,
  parameter int ADDR_W      = 32
) (
  input  logic                            qdr_clk,
  input  logic                            sys_rst,
  input  logic [ADDR_W-1:0]               addr,
  input  logic                            rd_en,
  input  logic                            wr_en,
  input  logic [qdr_pkg::QDR_LANES-1:0]   be,
  input  logic [qdr_pkg::QDR_WORD_W-1:0]  wr_data,
  output logic [qdr_pkg::QDR_WORD_W-1:0]  rd_data
);

  logic                         rd_tag_valid;
  logic [$clog2(NUM_BANKS)-1:0] rd_tag_bank;

  qdr_bank_if #(
    .BANK_DEPTH (BANK_DEPTH)
  ) bank_bus [NUM_BANKS] ();

  qdr_req_decode #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH),
    .ADDR_W     (ADDR_W)
  ) u_req_decode (
    .qdr_clk      (qdr_clk),
    .sys_rst      (sys_rst),
    .addr         (addr),
    .rd_en        (rd_en),
    .wr_en        (wr_en),
    .be           (be),
    .wr_data      (wr_data),
    .bank_if      (bank_bus),
    .rd_tag_valid (rd_tag_valid),
    .rd_tag_bank  (rd_tag_bank)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    qdr_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .qdr_clk (qdr_clk),
      .bus     (bank_bus[i])
    );
  end

  qdr_read_return #(
    .NUM_BANKS   (NUM_BANKS),
    .QDR_LATENCY (QDR_LATENCY)
  ) u_read_return (
    .qdr_clk      (qdr_clk),
    .sys_rst      (sys_rst),
    .bank_if      (bank_bus),
    .rd_tag_valid (rd_tag_valid),
    .rd_tag_bank  (rd_tag_bank),
    .rd_data      (rd_data)
  );

endmodule

`default_nettype wire

// ==== tb_qdr_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_qdr_subsystem;

  localparam int NUM_BANKS      = 4;
  localparam int BANK_DEPTH     = 1024;
  localparam int QDR_LATENCY    = 10;
  localparam int ADDR_W         = 32;
  localparam int ROW_W          = $clog2(BANK_DEPTH);
  localparam int BANK_W         = $clog2(NUM_BANKS);
  localparam int WORD_W         = 36;
  localparam int CLK_HALF       = 2;
  localparam int DRIVE_DLY      = 1;
  localparam int PIPE_READS     = 256;
  localparam int TIMEOUT_CYCLES = 3000; // roughly twice the length of all tests.

  logic              qdr_clk;
  logic              sys_rst;
  logic [ADDR_W-1:0] addr;
  logic              rd_en;
  logic              wr_en;
  logic [3:0]        be;
  logic [WORD_W-1:0] wr_data;
  logic [WORD_W-1:0] rd_data;

  logic [8:0]        ref_mem [NUM_BANKS][BANK_DEPTH][8]; // bank, row, lane.
  logic [WORD_W-1:0] exp_rd [int]; // expected read beat, keyed by cycle.
  int                cycle = 0;
  logic              mon_en = 1'b0;
  string             test_name = "reset";

  qdr_subsystem dut_i (
    .qdr_clk (qdr_clk),
    .sys_rst (sys_rst),
    .addr    (addr),
    .rd_en   (rd_en),
    .wr_en   (wr_en),
    .be      (be),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  initial begin
    qdr_clk = 1'b0;
    forever #CLK_HALF qdr_clk = ~qdr_clk;
  end

  always @(posedge qdr_clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("sim failed");
      $fatal(1, "timeout, the tests did not finish within %0d cycles", cycle);
    end
  end

  task automatic check_value(input string label, input logic [WORD_W-1:0] expected,
                             input logic [WORD_W-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", label, expected, actual);
      $display("sim failed");
      $fatal(1, "read data mismatch");
    end
  endtask

  // rd_data only changes on rising edges, so the falling edge is a safe sample point.
  always @(negedge qdr_clk) begin
    if (mon_en) begin
      if (exp_rd.exists(cycle)) begin
        check_value($sformatf("%s at cycle %0d", test_name, cycle), exp_rd[cycle], rd_data);
        exp_rd.delete(cycle);
      end else begin
        check_value($sformatf("%s at cycle %0d", test_name, cycle), '0, rd_data);
      end
    end
  end

  function automatic logic [BANK_W-1:0] bank_of(input logic [ADDR_W-1:0] a);
    return a[ROW_W +: BANK_W];
  endfunction

  function automatic logic [ROW_W-1:0] row_of(input logic [ADDR_W-1:0] a);
    return a[ROW_W-1:0];
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(input logic [BANK_W-1:0] b,
                                                  input logic [ROW_W-1:0] r);
    logic [ADDR_W-1:0] a;
    a = '0;
    a[ROW_W +: BANK_W] = b;
    a[ROW_W-1:0] = r;
    return a;
  endfunction

  function automatic logic [WORD_W-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $urandom();
    lo = $urandom();
    return {hi[3:0], lo};
  endfunction

  // upper selects lanes 4 to 7, otherwise lanes 0 to 3.
  function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] a, input logic upper);
    logic [BANK_W-1:0] b;
    logic [ROW_W-1:0]  r;
    logic [2:0]        base;
    b = bank_of(a);
    r = row_of(a);
    base = upper ? 3'd4 : 3'd0;
    return {ref_mem[b][r][base + 3'd3], ref_mem[b][r][base + 3'd2],
            ref_mem[b][r][base + 3'd1], ref_mem[b][r][base]};
  endfunction

  task automatic ref_write(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d,
                           input logic [3:0] mask, input logic upper);
    logic [BANK_W-1:0] b;
    logic [ROW_W-1:0]  r;
    logic [2:0]        lane;
    b = bank_of(a);
    r = row_of(a);
    lane = upper ? 3'd4 : 3'd0;
    for (int l = 0; l < 4; l++) begin
      if (mask[0]) begin
        ref_mem[b][r][lane] = d[8:0];
      end
      mask = mask >> 1;
      d = d >> 9;
      lane = lane + 3'd1;
    end
  endtask

  task automatic next_cycle();
    @(posedge qdr_clk);
    #DRIVE_DLY;
  endtask

  task automatic drain();
    repeat (QDR_LATENCY + 2) next_cycle();
  endtask

  task automatic expect_read(input int k, input logic [ADDR_W-1:0] a);
    exp_rd[k + QDR_LATENCY - 1] = ref_word(a, 1'b0);
    exp_rd[k + QDR_LATENCY]     = ref_word(a, 1'b1);
  endtask

  task automatic write_burst(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d0,
                             input logic [3:0] be0, input logic [WORD_W-1:0] d1,
                             input logic [3:0] be1);
    addr = a;
    wr_en = 1'b1;
    wr_data = d0;
    be = be0;
    next_cycle();
    addr = ~a; // the second beat must use the registered address.
    wr_en = 1'b0;
    wr_data = d1;
    be = be1;
    next_cycle();
    wr_data = '0;
    be = '0;
    ref_write(a, d0, be0, 1'b0);
    ref_write(a, d1, be1, 1'b1);
  endtask

  task automatic read_burst(input logic [ADDR_W-1:0] a);
    int k;
    k = cycle + 1; // the edge that samples the strobe.
    expect_read(k, a);
    addr = a;
    rd_en = 1'b1;
    next_cycle();
    addr = ~a;
    rd_en = 1'b0;
    next_cycle();
  endtask

  task automatic test_full_burst();
    logic [BANK_W-1:0] b;
    test_name = "full_burst";
    b = '0;
    repeat (NUM_BANKS) begin
      write_burst(make_addr(b, ROW_W'(7)), rand_word(), 4'hf, rand_word(), 4'hf);
      b = b + BANK_W'(1);
    end
    repeat (NUM_BANKS) begin
      read_burst(make_addr(b, ROW_W'(7)));
      b = b + BANK_W'(1);
    end
    drain();
  endtask

  task automatic test_byte_enables();
    logic [3:0]        pat;
    logic [BANK_W-1:0] b;
    logic [ADDR_W-1:0] a;
    test_name = "byte_enables";
    pat = '0;
    b = '0;
    repeat (16) begin
      a = make_addr(b, ROW_W'(512) | ROW_W'(pat));
      write_burst(a, rand_word(), 4'hf, rand_word(), 4'hf);
      write_burst(a, rand_word(), pat, rand_word(), ~pat);
      read_burst(a);
      pat = pat + 4'd1;
      b = b + BANK_W'(1);
    end
    drain();
  endtask

  task automatic test_read_priority();
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] other;
    int                k;
    test_name = "read_priority";
    a = make_addr(BANK_W'(2), ROW_W'(85));
    other = make_addr(BANK_W'(3), ROW_W'(102));
    write_burst(a, 36'h1_2345_6789, 4'hf, 36'h9_8765_4321, 4'hf);
    write_burst(other, 36'h5_5555_5555, 4'hf, 36'ha_aaaa_aaaa, 4'hf);
    k = cycle + 1;
    expect_read(k, a);
    addr = a;
    rd_en = 1'b1;
    wr_en = 1'b1; // collides with the first read beat and is dropped.
    be = 4'hf;
    wr_data = 36'hf_0f0f_0f0f;
    next_cycle();
    addr = other;
    rd_en = 1'b1; // lands on the second read beat.
    wr_en = 1'b0;
    wr_data = 36'h0_f0f0_f0f0;
    next_cycle();
    rd_en = 1'b0;
    be = '0;
    wr_data = '0;
    read_burst(a);
    read_burst(other);
    drain();
  endtask

  task automatic test_pipelined_reads();
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] addr_q [$];
    logic [31:0]       r32;
    logic [BANK_W-1:0] b;
    test_name = "pipelined_reads";
    b = '0;
    repeat (PIPE_READS) begin
      r32 = $urandom();
      a = make_addr(b, r32[ROW_W-1:0]);
      write_burst(a, rand_word(), 4'hf, rand_word(), 4'hf);
      addr_q.push_back(a);
      b = b + BANK_W'(1); // neighbouring reads hit different banks.
    end
    while (addr_q.size() > 0) begin
      read_burst(addr_q.pop_front());
    end
    drain();
  endtask

  task automatic test_address_alias();
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] alias_lo;
    logic [ADDR_W-1:0] alias_hi;
    logic [BANK_W-1:0] b;
    test_name = "address_alias";
    b = '0;
    repeat (NUM_BANKS) begin
      base = make_addr(b, ROW_W'(291));
      alias_lo = base | (ADDR_W'(1) << (ROW_W + BANK_W));
      alias_hi = base ^ ({ADDR_W{1'b1}} << (ROW_W + BANK_W));
      write_burst(alias_lo, rand_word(), 4'hf, rand_word(), 4'hf);
      read_burst(base);
      read_burst(alias_hi);
      write_burst(alias_hi, rand_word(), 4'hf, rand_word(), 4'hf);
      read_burst(alias_lo);
      b = b + BANK_W'(1);
    end
    drain();
  endtask

  initial begin
    void'($urandom(32'h1bc7_7d3b));
    sys_rst = 1'b1;
    addr = '0;
    rd_en = 1'b0;
    wr_en = 1'b0;
    be = '0;
    wr_data = '0;
    repeat (8) @(posedge qdr_clk);
    #DRIVE_DLY;
    sys_rst = 1'b0;
    mon_en = 1'b1;

    test_full_burst();
    test_byte_enables();
    test_read_priority();
    test_pipelined_reads();
    test_address_alias();

    if (exp_rd.num() != 0) begin
      $display("%0d expected read beats were never returned", exp_rd.num());
      $display("sim failed");
      $fatal(1, "read beats missing at the end of the run");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
qdr_pkg.sv
qdr_bank_if.sv
qdr_req_decode.sv
qdr_bank.sv
qdr_read_return.sv
qdr_subsystem.sv
tb_qdr_subsystem.sv

// ==== Makefile ====
# Verilator flow for the QDR subsystem testbench.
# Any variable below can be overridden, e.g. make sim JOBS=4

VERILATOR ?= verilator
TOP       ?= tb_qdr_subsystem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing
LINT_ARGS ?= --lint-only
SIM_ARGS  ?=

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_ARGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status, which fails this target.
sim: $(BIN)
	./$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
